/* design/line_swap_pkg.sv */
package line_swap_pkg;

    // Camera word, pixel clock on top and RGB888 at the bottom.
    typedef logic [48:0] cam_pack_t;

    localparam int PACK_CLK     = 48; // Ignored, streams are already in rclk.
    localparam int PACK_VSYNC   = 47;
    localparam int PACK_HSYNC   = 46;
    localparam int PACK_DE      = 45;
    localparam int PACK_RSV_LSB = 24;
    localparam int PACK_RSV_W   = 21;
    localparam int PACK_RED_LSB = 16;
    localparam int PACK_GRN_LSB = 8;
    localparam int PACK_BLU_LSB = 0;

    // RGB565, red in the high bits.
    typedef logic [15:0] pixel_t;

    typedef logic [7:0] byte_t;

    typedef logic [9:0] row_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_VSYNC,
        WAIT_CAM1,
        READ_CAM1,
        WAIT_CAM2,
        READ_CAM2
    } swap_state_t;

endpackage : line_swap_pkg

/* design/cam_stream_if.sv */
interface cam_stream_if;

    logic                  vsync;
    logic                  vsync_fall; // One cycle at the end of vsync.
    logic                  de;         // Write strobe into the line FIFO.
    line_swap_pkg::pixel_t pixel;

    modport src (
        output vsync, vsync_fall, de, pixel
    );

    modport fifo (
        input de, pixel
    );

    modport ctrl (
        input vsync, vsync_fall
    );

endinterface : cam_stream_if

/* design/cam_decode.sv */
module cam_decode (
    input  logic                     rclk,
    input  logic                     rstn,
    input  line_swap_pkg::cam_pack_t pack,
    cam_stream_if.src                cam
);

    logic                  pack_vsync;
    logic                  pack_de;
    line_swap_pkg::pixel_t pack_pixel;

    assign pack_vsync = pack[line_swap_pkg::PACK_VSYNC];
    assign pack_de    = pack[line_swap_pkg::PACK_DE];

    // Keep the top bits of each colour.
    assign pack_pixel = {
        pack[line_swap_pkg::PACK_RED_LSB + 3 +: 5],
        pack[line_swap_pkg::PACK_GRN_LSB + 2 +: 6],
        pack[line_swap_pkg::PACK_BLU_LSB + 3 +: 5]
    };

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            cam.vsync      <= 1'b0;
            cam.vsync_fall <= 1'b0;
            cam.de         <= 1'b0;
        end else begin
            cam.vsync      <= pack_vsync;
            // Registered vsync is the previous sample.
            cam.vsync_fall <= cam.vsync && !pack_vsync;
            cam.de         <= pack_de;
        end
    end

    always_ff @(posedge rclk) begin
        cam.pixel <= pack_pixel;
    end

endmodule : cam_decode

/* design/line_fifo.sv */
module line_fifo #(
    parameter int H_ACT = 1280
) (
    input  logic                rclk,
    input  logic                rstn,
    input  logic                flush,
    input  logic                rd_en,
    cam_stream_if.fifo          cam,
    output logic                ready,
    output logic                overflow,
    output line_swap_pkg::byte_t rd_data
);

    localparam int DEPTH = 2 * H_ACT;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    line_swap_pkg::pixel_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;   // Pixels held, a half-read one included.
    logic          byte_sel; // Low byte of the current pixel is next.
    logic          full;
    logic          wr_ok;
    logic          pix_done;

    assign full     = (count == CW'(DEPTH));
    assign ready    = (count >= CW'(H_ACT));
    assign wr_ok    = cam.de && !full && !flush;
    assign pix_done = rd_en && byte_sel && !flush;

    always_ff @(posedge rclk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= cam.pixel;
        end
        if (rd_en) begin
            rd_data <= byte_sel ? mem[rd_ptr][7:0] : mem[rd_ptr][15:8]; // High byte first.
        end
    end

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            byte_sel <= 1'b0;
            overflow <= 1'b0;
        end else if (flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            byte_sel <= 1'b0;
            overflow <= 1'b0;
        end else begin
            overflow <= cam.de && full;
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                byte_sel <= !byte_sel;
            end
            if (pix_done) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, pix_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The controller only reads what the ready level promised.
    a_no_read_empty: assert property (@(posedge rclk) disable iff (!rstn)
        rd_en |-> (count != '0));

    a_flush_clears: assert property (@(posedge rclk) disable iff (!rstn)
        flush |=> (count == '0));

endmodule : line_fifo

/* design/line_swap_ctrl.sv */
module line_swap_ctrl #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic                 rclk,
    input  logic                 rstn,
    input  logic                 trig,
    input  logic                 read_en,
    cam_stream_if.ctrl           cam1,
    cam_stream_if.ctrl           cam2,
    input  logic                 ready1,
    input  logic                 ready2,
    input  line_swap_pkg::byte_t rd_data1,
    input  line_swap_pkg::byte_t rd_data2,
    output logic                 flush,
    output logic                 rd_en1,
    output logic                 rd_en2,
    output logic                 aquire,
    output logic                 cam_id,
    output logic                 valid,
    output logic                 vs_err,
    output line_swap_pkg::byte_t cam_data,
    output line_swap_pkg::row_t  cam_row
);

    localparam int NBYTES = 2 * H_ACT;
    localparam int BW     = $clog2(NBYTES + 1);

    line_swap_pkg::swap_state_t state;
    line_swap_pkg::row_t        row;

    logic [BW-1:0] req_cnt; // Bytes requested in the current line.
    logic          req_open;
    logic          line_done;

    assign flush = (state == line_swap_pkg::IDLE) || (state == line_swap_pkg::WAIT_VSYNC);
    assign req_open = read_en && (req_cnt < BW'(NBYTES));
    // Last request already out and its byte is on cam_data now.
    assign line_done = valid && !rd_en1 && !rd_en2 && (req_cnt == BW'(NBYTES));
    assign cam_data = cam_id ? rd_data2 : rd_data1;
    assign cam_row  = row;

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state   <= line_swap_pkg::IDLE;
            row     <= '0;
            req_cnt <= '0;
            rd_en1  <= 1'b0;
            rd_en2  <= 1'b0;
            aquire  <= 1'b0;
            cam_id  <= 1'b0;
            valid   <= 1'b0;
            vs_err  <= 1'b0;
        end else begin
            aquire <= 1'b0;
            vs_err <= 1'b0;
            rd_en1 <= 1'b0;
            rd_en2 <= 1'b0;
            valid  <= rd_en1 || rd_en2; // FIFO data lands one cycle later.
            case (state)
                line_swap_pkg::IDLE: begin
                    cam_id <= 1'b0;
                    if (trig) begin
                        state <= line_swap_pkg::WAIT_VSYNC;
                    end
                end
                line_swap_pkg::WAIT_VSYNC: begin
                    if (cam1.vsync_fall != cam2.vsync_fall) begin
                        vs_err <= 1'b1; // Cameras out of step.
                        state  <= line_swap_pkg::IDLE;
                    end else if (cam1.vsync && cam2.vsync) begin
                        row   <= '0;
                        state <= line_swap_pkg::WAIT_CAM1;
                    end
                end
                line_swap_pkg::WAIT_CAM1: begin
                    req_cnt <= '0;
                    if (ready1) begin
                        aquire <= 1'b1;
                        state  <= line_swap_pkg::READ_CAM1;
                    end
                end
                line_swap_pkg::READ_CAM1: begin
                    if (req_open) begin
                        rd_en1  <= 1'b1;
                        req_cnt <= req_cnt + 1'b1;
                    end
                    if (line_done) begin
                        cam_id <= 1'b1;
                        state  <= line_swap_pkg::WAIT_CAM2;
                    end
                end
                line_swap_pkg::WAIT_CAM2: begin
                    req_cnt <= '0;
                    if (ready2) begin
                        aquire <= 1'b1;
                        state  <= line_swap_pkg::READ_CAM2;
                    end
                end
                line_swap_pkg::READ_CAM2: begin
                    if (req_open) begin
                        rd_en2  <= 1'b1;
                        req_cnt <= req_cnt + 1'b1;
                    end
                    if (line_done) begin
                        cam_id <= 1'b0;
                        if (row == line_swap_pkg::row_t'(V_ACT - 1)) begin
                            state <= line_swap_pkg::IDLE;
                        end else begin
                            row   <= row + 1'b1;
                            state <= line_swap_pkg::WAIT_CAM1;
                        end
                    end
                end
                default: begin
                    state <= line_swap_pkg::IDLE;
                end
            endcase
        end
    end

    a_valid_in_read: assert property (@(posedge rclk) disable iff (!rstn)
        valid |-> (state == line_swap_pkg::READ_CAM1 || state == line_swap_pkg::READ_CAM2));

    a_one_reader: assert property (@(posedge rclk) disable iff (!rstn)
        !(rd_en1 && rd_en2));

endmodule : line_swap_ctrl

/* design/fault_stretch.sv */
module fault_stretch #(
    parameter int ERR_HOLD = 1_000_000
) (
    input  logic rclk,
    input  logic rstn,
    input  logic ovf1,
    input  logic ovf2,
    input  logic vs_err,
    output logic error
);

    localparam int HW = $clog2(ERR_HOLD + 1);

    logic [HW-1:0] hold_cnt;
    logic          fault;

    assign fault = ovf1 || ovf2 || vs_err;
    assign error = (hold_cnt != '0);

    // Any fault restarts the hold window.
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            hold_cnt <= '0;
        end else if (fault) begin
            hold_cnt <= HW'(ERR_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

endmodule : fault_stretch

/* design/line_swap_buffer.sv */
module line_swap_buffer #(
    parameter int H_ACT    = 1280,
    parameter int V_ACT    = 720,
    parameter int ERR_HOLD = 1_000_000
) (
    input  logic        rclk,
    input  logic        rstn,
    input  logic        trig,
    input  logic        read_en,
    input  logic [48:0] cam1_pack,
    input  logic [48:0] cam2_pack,
    output logic        aquire,
    output logic        cam_id,
    output logic        valid,
    output logic        error,
    output logic [7:0]  cam_data,
    output logic [9:0]  cam_row
);

    logic                 flush;
    logic                 rd_en1;
    logic                 rd_en2;
    logic                 ready1;
    logic                 ready2;
    logic                 ovf1;
    logic                 ovf2;
    logic                 vs_err;
    line_swap_pkg::byte_t rd_data1;
    line_swap_pkg::byte_t rd_data2;

    cam_stream_if cam1_if ();
    cam_stream_if cam2_if ();

    cam_decode u_cam1_decode (
        .rclk (rclk),
        .rstn (rstn),
        .pack (cam1_pack),
        .cam  (cam1_if.src)
    );

    cam_decode u_cam2_decode (
        .rclk (rclk),
        .rstn (rstn),
        .pack (cam2_pack),
        .cam  (cam2_if.src)
    );

    line_fifo #(.H_ACT(H_ACT)) u_cam1_fifo (
        .rclk     (rclk),
        .rstn     (rstn),
        .flush    (flush),
        .rd_en    (rd_en1),
        .cam      (cam1_if.fifo),
        .ready    (ready1),
        .overflow (ovf1),
        .rd_data  (rd_data1)
    );

    line_fifo #(.H_ACT(H_ACT)) u_cam2_fifo (
        .rclk     (rclk),
        .rstn     (rstn),
        .flush    (flush),
        .rd_en    (rd_en2),
        .cam      (cam2_if.fifo),
        .ready    (ready2),
        .overflow (ovf2),
        .rd_data  (rd_data2)
    );

    line_swap_ctrl #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_ctrl (
        .rclk     (rclk),
        .rstn     (rstn),
        .trig     (trig),
        .read_en  (read_en),
        .cam1     (cam1_if.ctrl),
        .cam2     (cam2_if.ctrl),
        .ready1   (ready1),
        .ready2   (ready2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .flush    (flush),
        .rd_en1   (rd_en1),
        .rd_en2   (rd_en2),
        .aquire   (aquire),
        .cam_id   (cam_id),
        .valid    (valid),
        .vs_err   (vs_err),
        .cam_data (cam_data),
        .cam_row  (cam_row)
    );

    fault_stretch #(.ERR_HOLD(ERR_HOLD)) u_fault (
        .rclk   (rclk),
        .rstn   (rstn),
        .ovf1   (ovf1),
        .ovf2   (ovf2),
        .vs_err (vs_err),
        .error  (error)
    );

endmodule : line_swap_buffer

/* verification/tb_line_swap.sv */
module tb_line_swap;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_ACT     = 8;
    localparam int V_ACT     = 4;
    localparam int ERR_HOLD  = 16;
    localparam int NUM_TESTS = 6;
    localparam int GAP_MIN   = 60;
    localparam int GAP_MAX   = 90;
    localparam int LINE_B    = 2 * H_ACT;
    localparam int FRAME_CYC = V_ACT * (GAP_MAX + H_ACT) + 2 * V_ACT * 4 * LINE_B + 200;
    localparam int WDOG_CYC  = NUM_TESTS * FRAME_CYC;

    logic        rclk;
    logic        rstn;
    logic        trig;
    logic        read_en;
    logic [48:0] cam1_pack;
    logic [48:0] cam2_pack;
    logic        aquire;
    logic        cam_id;
    logic        valid;
    logic        error;
    logic [7:0]  cam_data;
    logic [9:0]  cam_row;

    logic [23:0] rgb_q1[$];
    logic [23:0] rgb_q2[$];
    int          errors = 0;
    int          rd_mode = 0; // 0 always high, 1 random gaps, 2 held low.
    bit          mon_on = 0;
    bit          acq_pending;
    int          acq_cnt;
    int          byte_idx;
    int          line_cnt;
    int          valid_total = 0;
    int          cyc = 0;
    int          last_de_cyc; // Last de pixel of camera 2.
    string       cur_test = "reset";

    line_swap_buffer #(.H_ACT(H_ACT), .V_ACT(V_ACT), .ERR_HOLD(ERR_HOLD)) dut (
        .rclk (rclk), .rstn (rstn), .trig (trig), .read_en (read_en),
        .cam1_pack (cam1_pack), .cam2_pack (cam2_pack),
        .aquire (aquire), .cam_id (cam_id), .valid (valid), .error (error),
        .cam_data (cam_data), .cam_row (cam_row)
    );

    initial begin
        rclk = 1'b0;
        forever #5 rclk = ~rclk;
    end

    always @(posedge rclk) cyc <= cyc + 1;

    always @(posedge rclk) begin
        case (rd_mode)
            0:       read_en <= 1'b1;
            1:       read_en <= ($urandom % 4) != 0; // Roughly one cycle in four paused.
            default: read_en <= 1'b0;
        endcase
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic logic [7:0] exp_byte(input int cam, input int row, input int idx);
        int          pix;
        logic [23:0] rgb;
        logic [15:0] p565;
        pix = row * H_ACT + idx / 2;
        if (cam == 1 && pix < rgb_q1.size()) rgb = rgb_q1[pix];
        else if (cam == 2 && pix < rgb_q2.size()) rgb = rgb_q2[pix];
        else return 8'hxx;
        p565 = {rgb[23:19], rgb[15:10], rgb[7:3]};
        return (idx % 2 == 0) ? p565[15:8] : p565[7:0];
    endfunction

    function automatic logic [48:0] make_pack(input logic vs, input logic de,
                                               input logic [23:0] rgb);
        line_swap_pkg::cam_pack_t p;
        p = '0;
        p[line_swap_pkg::PACK_VSYNC] = vs;
        p[line_swap_pkg::PACK_DE] = de;
        p[line_swap_pkg::PACK_BLU_LSB +: 24] = rgb;
        return p;
    endfunction

    task automatic drive_pack(input int cam, input logic [48:0] p);
        if (cam == 1) cam1_pack <= p;
        else cam2_pack <= p;
    endtask

    // Lines of de pixels with a random gap before each one.
    task automatic cam_lines(input int cam, input int rows, input int npix);
        logic [23:0] rgb;
        for (int r = 0; r < rows; r++) begin
            repeat (GAP_MIN + $urandom % (GAP_MAX - GAP_MIN + 1)) @(posedge rclk);
            for (int i = 0; i < npix; i++) begin
                @(posedge rclk);
                rgb = 24'($urandom);
                if (cam == 1) rgb_q1.push_back(rgb);
                else rgb_q2.push_back(rgb);
                drive_pack(cam, make_pack(1'b0, 1'b1, rgb));
                if (cam == 2) begin
                    last_de_cyc = cyc;
                end
            end
            @(posedge rclk);
            drive_pack(cam, '0);
        end
    endtask

    task automatic start_frame();
        rgb_q1.delete();
        rgb_q2.delete();
        @(posedge rclk);
        cam1_pack <= make_pack(1'b1, 1'b0, '0);
        cam2_pack <= make_pack(1'b1, 1'b0, '0);
        @(posedge rclk);
        trig <= 1'b1;
        @(posedge rclk);
        trig <= 1'b0;
        repeat (4) @(posedge rclk);
        cam1_pack <= '0; // Both vsyncs end together.
        cam2_pack <= '0;
    endtask

    task automatic run_frame(input string name, input int mode);
        cur_test = name;
        rd_mode = mode;
        acq_pending = 0;
        acq_cnt = 0;
        byte_idx = 0;
        line_cnt = 0;
        mon_on = 1;
        start_frame();
        fork
            cam_lines(1, V_ACT, H_ACT);
            cam_lines(2, V_ACT, H_ACT);
        join
        wait (line_cnt == 2 * V_ACT);
        repeat (5) @(posedge rclk);
        mon_on = 0;
        check({name, " aquire count"}, 2 * V_ACT, acq_cnt);
        check({name, " partial line bytes"}, 0, byte_idx);
        check({name, " error"}, 0, error);
    endtask

    always @(posedge rclk) begin
        if (rstn) begin
            if (valid) valid_total++;
            if (mon_on && aquire) begin
                if (acq_pending) begin
                    $display("Second aquire pulse before a line started in %s", cur_test);
                    errors++;
                end
                acq_pending = 1;
                acq_cnt++;
            end
            if (mon_on && valid) begin
                if (byte_idx == 0) begin
                    if (!acq_pending) begin
                        $display("Line started without an aquire pulse in %s", cur_test);
                        errors++;
                    end
                    acq_pending = 0;
                end
                check({cur_test, " cam_data"},
                      exp_byte(line_cnt % 2 + 1, line_cnt / 2, byte_idx), cam_data);
                check({cur_test, " cam_id"}, line_cnt % 2, cam_id);
                check({cur_test, " cam_row"}, line_cnt / 2, cam_row);
                byte_idx++;
                if (byte_idx == LINE_B) begin
                    byte_idx = 0;
                    line_cnt++;
                end
            end
        end
    end

    initial begin
        repeat (WDOG_CYC) @(posedge rclk);
        $display("Watchdog expired, the tests did not finish in %0d cycles.", WDOG_CYC);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int seen;
        int n;
        int valid_start;
        void'($urandom(32'h2591_0940));
        rstn = 1'b0;
        trig = 1'b0;
        read_en = 1'b0;
        cam1_pack = '0;
        cam2_pack = '0;
        repeat (4) @(posedge rclk);
        rstn <= 1'b1;
        @(posedge rclk);
        check("reset aquire", 0, aquire);
        check("reset valid", 0, valid);
        check("reset cam_id", 0, cam_id);
        check("reset error", 0, error);

        run_frame("interleave", 0);
        repeat (10) @(posedge rclk);
        run_frame("backpressure", 1);
        repeat (10) @(posedge rclk);

        // Camera 1 leaves vsync alone while camera 2 never entered it.
        cur_test = "vsync_mismatch";
        rd_mode = 0;
        valid_start = valid_total;
        @(posedge rclk);
        cam1_pack <= make_pack(1'b1, 1'b0, '0);
        @(posedge rclk);
        trig <= 1'b1;
        @(posedge rclk);
        trig <= 1'b0;
        repeat (3) @(posedge rclk);
        cam1_pack <= '0;
        seen = 0;
        for (int i = 0; i < 8 && !seen; i++) begin
            @(posedge rclk);
            if (error) seen = 1;
        end
        if (!seen) begin
            $display("Vsync mismatch did not raise error within 8 cycles.");
            errors++;
        end
        repeat (20) @(posedge rclk);
        check("vsync_mismatch valid count", 0, valid_total - valid_start);
        run_frame("after_mismatch", 0);
        repeat (10) @(posedge rclk);

        // Camera 2 writes past the FIFO depth while reads are held off.
        cur_test = "overflow";
        rd_mode = 2;
        start_frame();
        fork
            cam_lines(1, 1, H_ACT);
            cam_lines(2, 1, 2 * H_ACT + 4);
        join
        // Pack register, decode, overflow flag and stretcher load come first.
        n = 0;
        seen = 0;
        while (n < ERR_HOLD + 20 && !(seen && !error)) begin
            @(posedge rclk);
            if (error) seen = 1;
            n = cyc - last_de_cyc;
        end
        if (!seen) begin
            $display("Overflow on camera 2 did not raise error.");
            errors++;
        end else if (n < ERR_HOLD + 3 || n > ERR_HOLD + 5) begin
            check("overflow error fall cycle", ERR_HOLD + 4, n);
        end

        $display("Checks done, error count %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_line_swap

/* compile.f */
design/line_swap_pkg.sv
design/cam_stream_if.sv
design/cam_decode.sv
design/line_fifo.sv
design/line_swap_ctrl.sv
design/fault_stretch.sv
design/line_swap_buffer.sv
verification/tb_line_swap.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_line_swap
RTL_TOP   = line_swap_buffer
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -Wno-fatal --top-module $(RTL_TOP) \
		design/line_swap_pkg.sv design/cam_stream_if.sv design/cam_decode.sv \
		design/line_fifo.sv design/line_swap_ctrl.sv design/fault_stretch.sv \
		design/line_swap_buffer.sv

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
